// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_subsystem_tb -f src.f -o sim_mem

# the testbench reports assertion failures itself, so the run continues past $error.
./obj_dir/sim_mem +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
grep -q "Simulation PASSED" sim.log

// ==== src.f ====
verilog/mem_sys_pkg.sv
verilog/hasti_stall_shim.sv
verilog/hasti_converter.sv
verilog/bank_crossbar.sv
verilog/mem_bank.sv
verilog/bank_response_mux.sv
verilog/mem_subsystem_top.sv
tests/mem_subsystem_properties.sv
tests/mem_subsystem_tb.sv

// ==== tests/mem_subsystem_properties.sv ====
`timescale 1ns/1ns

module mem_subsystem_properties
  ( input clk_i
   ,input reset_i
   ,input stall_i

   ,input mem_sys_pkg::hasti_req_s [mem_sys_pkg::num_ports_lp-1:0] hasti_req_i
   ,input mem_sys_pkg::hasti_rsp_s [mem_sys_pkg::num_ports_lp-1:0] hasti_rsp_i

   ,input [mem_sys_pkg::num_ports_lp-1:0]                          m_v_i
   ,input [mem_sys_pkg::num_ports_lp-1:0]                          m_yumi_i
   ,input mem_sys_pkg::mem_req_s [mem_sys_pkg::num_ports_lp-1:0]   m_req_i
  );
  import mem_sys_pkg::*;

  int unsigned fail_count = 0;  // read by the testbench after each cycle.

  // --------------------------------------------------------------------------
  // master side
  // --------------------------------------------------------------------------
  port0_no_write: assert property (@(posedge clk_i) disable iff (reset_i)
      hasti_req_i[0].htrans == htrans_nonseq_lp |-> !hasti_req_i[0].hwrite)
    else
    begin
      fail_count++;
      $error("instruction port issued a write");
    end

  stall_holds_masters: assert property (@(posedge clk_i) disable iff (reset_i)
      stall_i |-> !hasti_rsp_i[0].hready && !hasti_rsp_i[1].hready)
    else
    begin
      fail_count++;
      $error("hready reached a master during a stall");
    end

  // --------------------------------------------------------------------------
  // valid/yumi toward the banks
  // --------------------------------------------------------------------------
  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      (m_yumi_i & ~m_v_i) == '0)
    else
    begin
      fail_count++;
      $error("yumi without valid");
    end

  for (genvar p = 0; p < num_ports_lp; p++)
  begin : g_port
    valid_held: assert property (@(posedge clk_i) disable iff (reset_i)
        m_v_i[p] && !m_yumi_i[p] |=> m_v_i[p] && $stable(m_req_i[p]))
      else
      begin
        fail_count++;
        $error("request dropped or changed before yumi");
      end
  end

endmodule

bind mem_subsystem_top mem_subsystem_properties i_mem_subsystem_properties
  ( .clk_i       (clk_i)
   ,.reset_i     (reset_i)
   ,.stall_i     (stall_i)
   ,.hasti_req_i (hasti_req_i)
   ,.hasti_rsp_i (hasti_rsp_o)
   ,.m_v_i       (m_v)
   ,.m_yumi_i    (m_yumi)
   ,.m_req_i     (m_req)
  );

// ==== tests/mem_subsystem_tb.sv ====
`timescale 1ns/1ns

module mem_subsystem_tb;
  import mem_sys_pkg::*;

  localparam int timeout_cycles_lp = 64;
  localparam int mem_bytes_lp      = num_banks_lp * bank_words_lp * 4;

  logic clk;
  logic reset;
  logic stall;

  hasti_req_s [num_ports_lp-1:0] hasti_req;
  hasti_rsp_s [num_ports_lp-1:0] hasti_rsp;

  logic [7:0]  ref_mem [mem_bytes_lp];
  logic [31:0] rand_state;
  logic        traffic_done;
  haddr_t      written_q [$];

  mem_subsystem_top i_mem_subsystem_top
    ( .clk_i       (clk)
     ,.reset_i     (reset)
     ,.stall_i     (stall)
     ,.hasti_req_i (hasti_req)
     ,.hasti_rsp_o (hasti_rsp)
    );

  always #4 clk = ~clk;

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
      fail_now($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                         $time, what, got, exp));
  endtask

  function automatic logic [31:0] next_rand();
    rand_state ^= rand_state << 13;
    rand_state ^= rand_state >> 17;
    rand_state ^= rand_state << 5;
    return rand_state;
  endfunction

  function automatic hsize_t rand_size();
    logic [31:0] r;
    r = next_rand();
    case (r % 3)
      0:       return hsize_byte_lp;
      1:       return hsize_half_lp;
      default: return hsize_word_lp;
    endcase
  endfunction

  function automatic haddr_t align_addr(input haddr_t a, input hsize_t sz);
    if (sz == hsize_word_lp)
      return {a[31:2], 2'b00};
    if (sz == hsize_half_lp)
      return {a[31:1], 1'b0};
    return a;
  endfunction

  // bytes come from their own lanes of hwdata.
  function automatic void ref_write(input haddr_t a, input hsize_t sz, input hdata_t wd);
    int n;
    n = 1 << sz;
    for (int i = 0; i < n; i++)
      ref_mem[a + i] = wd[8 * ((int'(a[1:0]) + i) % 4) +: 8];
  endfunction

  function automatic hdata_t ref_read(input haddr_t a);
    int b;
    b = int'({a[31:2], 2'b00});
    return {ref_mem[b + 3], ref_mem[b + 2], ref_mem[b + 1], ref_mem[b]};
  endfunction

  // one non-pipelined transfer; cycles counts edges from address phase to data end.
  task automatic xfer(input int p, input logic wr, input haddr_t a, input hsize_t sz,
                      input hdata_t wd, output hdata_t rd, output int cycles);
    int   waited;
    logic ready;
    hasti_req[p].haddr  = a;
    hasti_req[p].hwrite = wr;
    hasti_req[p].hsize  = sz;
    hasti_req[p].htrans = htrans_nonseq_lp;
    waited = 0;
    ready  = 1'b0;
    while (!ready)
    begin
      @(negedge clk);
      ready = hasti_rsp[p].hready;
      @(posedge clk);
      #1;
      waited++;
      if (!ready && waited > timeout_cycles_lp)
        fail_now($sformatf("Timeout: port %0d address phase was never accepted", p));
    end
    hasti_req[p].htrans = htrans_idle_lp;
    hasti_req[p].hwdata = wd;
    cycles = 0;
    ready  = 1'b0;
    while (!ready)
    begin
      @(negedge clk);
      ready = hasti_rsp[p].hready;
      rd    = hasti_rsp[p].hrdata;
      @(posedge clk);
      #1;
      cycles++;
      if (!ready && cycles > timeout_cycles_lp)
        fail_now($sformatf("Timeout: port %0d data phase never ended", p));
    end
  endtask

  task automatic read_check(input int p, input haddr_t a);
    hdata_t rd;
    int     cycles;
    xfer(p, 1'b0, align_addr(a, hsize_word_lp), hsize_word_lp, '0, rd, cycles);
    check_value($sformatf("port %0d read of %h", p, a), rd, ref_read(a));
  endtask

  task automatic write_data(input haddr_t a, input hsize_t sz, input hdata_t wd);
    hdata_t rd;
    int     cycles;
    xfer(1, 1'b1, a, sz, wd, rd, cycles);
    ref_write(a, sz, wd);
    check_value($sformatf("port 1 write response of %h", a), rd, ref_read(a));
  endtask

  // --------------------------------------------------------------------------
  // behaviors
  // --------------------------------------------------------------------------
  task automatic check_after_reset();
    @(negedge clk);
    check_value("port 0 hready after reset", hasti_rsp[0].hready, 1);
    check_value("port 1 hready after reset", hasti_rsp[1].hready, 1);
    @(posedge clk);
    #1;
    read_check(0, 32'hffc);
  endtask

  task automatic write_then_read_back();
    haddr_t a;
    hsize_t sz;
    for (int i = 0; i < 24; i++)
    begin
      sz = rand_size();
      a  = align_addr(next_rand() & 32'h7ff, sz);
      write_data(a, sz, next_rand());
      written_q.push_back(a);
    end
    foreach (written_q[i])
      read_check(1, written_q[i]);
  endtask

  task automatic access_parallel_banks();
    haddr_t a0;
    haddr_t a1;
    hsize_t sz;
    hdata_t wd;
    hdata_t rd0;
    hdata_t rd1;
    int     lat0;
    int     lat1;
    for (int i = 0; i < 8; i++)
    begin
      a0 = next_rand() & 32'hffc;
      sz = rand_size();
      a1 = align_addr((next_rand() & 32'hff3) | ((a0 & 32'hc) ^ 32'h4), sz);
      wd = next_rand();
      fork
        xfer(0, 1'b0, a0, hsize_word_lp, '0, rd0, lat0);
        xfer(1, 1'b1, a1, sz, wd, rd1, lat1);
      join
      ref_write(a1, sz, wd);
      check_value("parallel read data", rd0, ref_read(a0));
      check_value("parallel write response", rd1, ref_read(a1));
      check_value("parallel read latency", lat0, 2);
      check_value("parallel write latency", lat1, 2);
    end
  endtask

  task automatic contend_for_one_bank();
    haddr_t a0;
    haddr_t a1;
    hdata_t wd;
    hdata_t rd0;
    hdata_t rd1;
    int     lat0;
    int     lat1;
    int     winner;
    int     last_winner;
    last_winner = -1;
    for (int i = 0; i < 6; i++)
    begin
      a0 = 32'h8 | ((next_rand() & 32'hff) << 4);  // always bank 2.
      a1 = a0 ^ 32'h10;
      wd = next_rand();
      fork
        xfer(0, 1'b0, a0, hsize_word_lp, '0, rd0, lat0);
        xfer(1, 1'b1, a1, hsize_word_lp, wd, rd1, lat1);
      join
      ref_write(a1, hsize_word_lp, wd);
      check_value("conflict read data", rd0, ref_read(a0));
      check_value("conflict write response", rd1, ref_read(a1));
      check_value("conflict latency sum", lat0 + lat1, 5);
      winner = (lat0 < lat1) ? 0 : 1;
      if (last_winner >= 0)
        check_value("conflict winner", winner, 1 - last_winner);
      last_winner = winner;
      read_check(1, a1);
    end
  endtask

  task automatic drive_stalls();
    int gap;
    int len;
    int guard;
    guard = 0;
    while (!traffic_done && guard < 4000)
    begin
      gap = 1 + next_rand() % 5;
      repeat (gap)
      begin
        @(posedge clk);
        #1;
        guard++;
      end
      if (!traffic_done)
      begin
        stall = 1'b1;
        len   = 1 + next_rand() % 4;
        repeat (len)
        begin
          @(posedge clk);
          #1;
          guard++;
        end
        stall = 1'b0;
      end
    end
    if (!traffic_done)
      fail_now("Timeout: traffic under stall did not finish");
  endtask

  task automatic traffic_under_stall();
    hsize_t sz;
    haddr_t a;
    traffic_done = 1'b0;
    fork
      begin
        fork
          for (int i = 0; i < 30; i++)
            read_check(0, next_rand() & 32'h7fc);
          for (int i = 0; i < 30; i++)
          begin
            if (next_rand() % 2)
            begin
              sz = rand_size();
              a  = align_addr(32'h800 | (next_rand() & 32'h7ff), sz);
              write_data(a, sz, next_rand());
              written_q.push_back(a);
            end
            else
              read_check(1, 32'h800 | (next_rand() & 32'h7fc));
          end
        join
        traffic_done = 1'b1;
      end
      drive_stalls();
    join
    foreach (written_q[i])
      read_check(0, written_q[i]);
  endtask

  // protocol assertions raise the counter, which ends the run here.
  always @(negedge clk)
  begin
    if (i_mem_subsystem_top.i_mem_subsystem_properties.fail_count != 0)
      fail_now("a protocol assertion failed");
  end

  initial
  begin
    clk          = 1'b0;
    reset        = 1'b1;
    stall        = 1'b0;
    traffic_done = 1'b0;
    rand_state   = 32'd84249;
    hasti_req    = '0;
    for (int i = 0; i < mem_bytes_lp; i++)
      ref_mem[i] = 8'h00;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    check_after_reset();
    write_then_read_back();
    access_parallel_banks();
    contend_for_one_bank();
    traffic_under_stall();

    if (i_mem_subsystem_top.i_mem_subsystem_properties.fail_count == 0)
    begin
      $display("Simulation PASSED");
      $finish;
    end
    else
      fail_now("a protocol assertion failed");
  end

endmodule

// ==== verilog/bank_crossbar.sv ====
`timescale 1ns/1ns

module bank_crossbar
  ( input clk_i
   ,input reset_i

   ,input  [mem_sys_pkg::num_ports_lp-1:0]                          m_v_i
   ,input  mem_sys_pkg::mem_req_s [mem_sys_pkg::num_ports_lp-1:0]   m_req_i
   ,output logic [mem_sys_pkg::num_ports_lp-1:0]                    m_yumi_o

   ,output logic [mem_sys_pkg::num_banks_lp-1:0]                    bank_v_o
   ,output mem_sys_pkg::bank_req_s [mem_sys_pkg::num_banks_lp-1:0]  bank_req_o
  );
  import mem_sys_pkg::*;

  bank_id_t   [num_ports_lp-1:0]                 port_bank;
  bank_addr_t [num_ports_lp-1:0]                 port_bank_addr;
  logic       [num_banks_lp-1:0][num_ports_lp-1:0] want;
  logic       [num_banks_lp-1:0]                 conflict;
  port_id_t   [num_banks_lp-1:0]                 winner;
  port_id_t   [num_banks_lp-1:0]                 prio_r;  // winner of the next conflict.

  // banks are interleaved on word address, the rest indexes the bank.
  always_comb
  begin
    for (int p = 0; p < num_ports_lp; p++)
    begin
      port_bank[p]      = m_req_i[p].addr[2 +: $bits(bank_id_t)];
      port_bank_addr[p] = m_req_i[p].addr[2 + $bits(bank_id_t) +: $bits(bank_addr_t)];
    end
  end

  always_comb
  begin
    for (int b = 0; b < num_banks_lp; b++)
    begin
      for (int p = 0; p < num_ports_lp; p++)
        want[b][p] = m_v_i[p] && (port_bank[p] == bank_id_t'(b));

      // two ports only, so without a conflict the single requester wins.
      conflict[b] = &want[b];
      winner[b]   = conflict[b] ? prio_r[b] : port_id_t'(want[b][1]);

      bank_v_o[b]             = |want[b];
      bank_req_o[b].w         = m_req_i[winner[b]].w;
      bank_req_o[b].bank_addr = port_bank_addr[winner[b]];
      bank_req_o[b].data      = m_req_i[winner[b]].data;
      bank_req_o[b].mask      = m_req_i[winner[b]].mask;
      bank_req_o[b].port      = winner[b];
    end

    for (int p = 0; p < num_ports_lp; p++)
      m_yumi_o[p] = m_v_i[p] && (winner[port_bank[p]] == port_id_t'(p));
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      prio_r <= '0;
    else
      for (int b = 0; b < num_banks_lp; b++)
      begin
        if (conflict[b])
          prio_r[b] <= ~winner[b];  // the loser goes first next time.
      end
  end

endmodule

// ==== verilog/bank_response_mux.sv ====
`timescale 1ns/1ns

module bank_response_mux
  ( input  [mem_sys_pkg::num_banks_lp-1:0]                          rsp_v_i
   ,input  mem_sys_pkg::bank_rsp_s [mem_sys_pkg::num_banks_lp-1:0]  rsp_i

   ,output logic [mem_sys_pkg::num_ports_lp-1:0]                    m_v_o
   ,output mem_sys_pkg::hdata_t [mem_sys_pkg::num_ports_lp-1:0]     m_data_o
  );
  import mem_sys_pkg::*;

  // --------------------------------------------------------------------------
  // one outstanding transfer per port, so at most one bank carries each tag.
  // --------------------------------------------------------------------------
  always_comb
  begin
    m_v_o    = '0;
    m_data_o = '0;
    for (int p = 0; p < num_ports_lp; p++)
    begin
      for (int b = 0; b < num_banks_lp; b++)
      begin
        if (rsp_v_i[b] && rsp_i[b].port == port_id_t'(p))
        begin
          m_v_o[p]    = 1'b1;
          m_data_o[p] = rsp_i[b].data;
        end
      end
    end
  end

endmodule

// ==== verilog/hasti_converter.sv ====
`timescale 1ns/1ns

module hasti_converter
  ( input clk_i
   ,input reset_i

   ,input  mem_sys_pkg::hasti_req_s [mem_sys_pkg::num_ports_lp-1:0] hasti_req_i
   ,output mem_sys_pkg::hasti_rsp_s [mem_sys_pkg::num_ports_lp-1:0] hasti_rsp_o

   ,output logic [mem_sys_pkg::num_ports_lp-1:0]                    m_v_o
   ,output mem_sys_pkg::mem_req_s [mem_sys_pkg::num_ports_lp-1:0]   m_req_o
   ,input  [mem_sys_pkg::num_ports_lp-1:0]                          m_yumi_i
   ,input  [mem_sys_pkg::num_ports_lp-1:0]                          m_v_i
   ,input  mem_sys_pkg::hdata_t [mem_sys_pkg::num_ports_lp-1:0]     m_data_i
  );
  import mem_sys_pkg::*;

  for (genvar p = 0; p < num_ports_lp; p++)
  begin : g_port
    conv_state_e state_r;
    haddr_t      addr_r;
    logic        write_r;
    hsize_t      size_r;
    hdata_t      rdata_r;
    hmask_t      wmask;
    logic        ready;
    logic        addr_phase;

    assign ready      = (state_r == idle) || (state_r == wait_rsp && m_v_i[p]);
    assign addr_phase = (hasti_req_i[p].htrans == htrans_nonseq_lp) && ready;

    always_ff @(posedge clk_i)
    begin
      if (reset_i)
        state_r <= idle;
      else if (addr_phase)
        state_r <= wait_yumi;  // also covers a new transfer in the last data cycle.
      else
        case (state_r)
          wait_yumi: if (m_yumi_i[p]) state_r <= wait_rsp;
          wait_rsp:  if (m_v_i[p])    state_r <= idle;
          default:   state_r <= idle;
        endcase

      if (addr_phase)
      begin
        addr_r  <= hasti_req_i[p].haddr;
        write_r <= hasti_req_i[p].hwrite;
        size_r  <= hasti_req_i[p].hsize;
      end

      // held until the next response so a stalled master still sees it.
      if (state_r == wait_rsp && m_v_i[p])
        rdata_r <= m_data_i[p];
    end

    always_comb
    begin
      unique case (size_r)
        hsize_byte_lp: wmask = hmask_t'(4'b0001) << addr_r[1:0];
        hsize_half_lp: wmask = hmask_t'(4'b0011) << {addr_r[1], 1'b0};
        default:       wmask = '1;
      endcase
    end

    // hwdata is expected on its byte lanes and is held through the data phase.
    assign m_v_o[p]        = (state_r == wait_yumi);
    assign m_req_o[p].w    = write_r;
    assign m_req_o[p].addr = {addr_r[haddr_width_lp-1:2], 2'b00};
    assign m_req_o[p].data = hasti_req_i[p].hwdata;
    assign m_req_o[p].mask = write_r ? wmask : '1;

    assign hasti_rsp_o[p].hready = ready;
    assign hasti_rsp_o[p].hrdata = m_v_i[p] ? m_data_i[p] : rdata_r;
  end

endmodule

// ==== verilog/hasti_stall_shim.sv ====
`timescale 1ns/1ns

module hasti_stall_shim
  ( input clk_i
   ,input reset_i
   ,input stall_i

   ,input  mem_sys_pkg::hasti_req_s [mem_sys_pkg::num_ports_lp-1:0] master_req_i
   ,output mem_sys_pkg::hasti_rsp_s [mem_sys_pkg::num_ports_lp-1:0] master_rsp_o

   ,output mem_sys_pkg::hasti_req_s [mem_sys_pkg::num_ports_lp-1:0] conv_req_o
   ,input  mem_sys_pkg::hasti_rsp_s [mem_sys_pkg::num_ports_lp-1:0] conv_rsp_i
  );
  import mem_sys_pkg::*;

  logic stall_r;

  hasti_req_s [num_ports_lp-1:0] req_r;
  hasti_rsp_s [num_ports_lp-1:0] rsp_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      stall_r <= 1'b0;
    else
      stall_r <= stall_i;

    // freeze both sides on the first stall cycle only.
    if (stall_i && !stall_r)
    begin
      req_r <= master_req_i;
      rsp_r <= conv_rsp_i;
    end
  end

  // --------------------------------------------------------------------------
  // stall_r high with stall_i low is the single replay cycle.
  // --------------------------------------------------------------------------
  always_comb
  begin
    for (int p = 0; p < num_ports_lp; p++)
    begin
      conv_req_o[p] = stall_r ? req_r[p] : master_req_i[p];

      if (stall_i)
        conv_req_o[p].htrans = htrans_idle_lp;
      else if (stall_r && !rsp_r[p].hready)
        conv_req_o[p].htrans = htrans_idle_lp;  // master did not see this address phase taken.

      master_rsp_o[p].hrdata = stall_r ? rsp_r[p].hrdata : conv_rsp_i[p].hrdata;

      if (stall_r && !stall_i)
        master_rsp_o[p].hready = rsp_r[p].hready;
      else
        master_rsp_o[p].hready = !stall_i && conv_rsp_i[p].hready;
    end
  end

  // A response that the converter finishes during the stall is not lost:
  // the converter keeps hrdata until its next transfer, and the master
  // sees it with hready once pass-through resumes.

endmodule

// ==== verilog/mem_bank.sv ====
`timescale 1ns/1ns

module mem_bank
  ( input clk_i
   ,input reset_i

   ,input                              v_i
   ,input  mem_sys_pkg::bank_req_s     req_i
   ,output logic                       rsp_v_o
   ,output mem_sys_pkg::bank_rsp_s     rsp_o
  );
  import mem_sys_pkg::*;

  hdata_t    mem_r [bank_words_lp] = '{default: '0};
  hdata_t    merged;
  bank_rsp_s rsp_r;

  // stored word with the masked write bytes laid over it.
  always_comb
  begin
    merged = mem_r[req_i.bank_addr];
    for (int i = 0; i < $bits(hmask_t); i++)
    begin
      if (req_i.w && req_i.mask[i])
        merged[8*i +: 8] = req_i.data[8*i +: 8];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rsp_v_o <= 1'b0;
    else
      rsp_v_o <= v_i;

    if (v_i)
    begin
      if (req_i.w)
        mem_r[req_i.bank_addr] <= merged;
      rsp_r.data <= merged;     // a write answers with the updated word.
      rsp_r.port <= req_i.port;
    end
  end

  assign rsp_o = rsp_r;

endmodule

// ==== verilog/mem_subsystem_top.sv ====
`timescale 1ns/1ns

module mem_subsystem_top
  ( input clk_i
   ,input reset_i
   ,input stall_i

   ,input  mem_sys_pkg::hasti_req_s [mem_sys_pkg::num_ports_lp-1:0] hasti_req_i
   ,output mem_sys_pkg::hasti_rsp_s [mem_sys_pkg::num_ports_lp-1:0] hasti_rsp_o
  );
  import mem_sys_pkg::*;

  hasti_req_s [num_ports_lp-1:0] conv_req;
  hasti_rsp_s [num_ports_lp-1:0] conv_rsp;

  logic       [num_ports_lp-1:0] m_v;
  mem_req_s   [num_ports_lp-1:0] m_req;
  logic       [num_ports_lp-1:0] m_yumi;
  logic       [num_ports_lp-1:0] rsp_m_v;
  hdata_t     [num_ports_lp-1:0] rsp_m_data;

  logic       [num_banks_lp-1:0] bank_v;
  bank_req_s  [num_banks_lp-1:0] bank_req;
  logic       [num_banks_lp-1:0] rsp_v;
  bank_rsp_s  [num_banks_lp-1:0] bank_rsp;

  hasti_stall_shim i_hasti_stall_shim
    ( .clk_i        (clk_i)
     ,.reset_i      (reset_i)
     ,.stall_i      (stall_i)
     ,.master_req_i (hasti_req_i)
     ,.master_rsp_o (hasti_rsp_o)
     ,.conv_req_o   (conv_req)
     ,.conv_rsp_i   (conv_rsp)
    );

  hasti_converter i_hasti_converter
    ( .clk_i       (clk_i)
     ,.reset_i     (reset_i)
     ,.hasti_req_i (conv_req)
     ,.hasti_rsp_o (conv_rsp)
     ,.m_v_o       (m_v)
     ,.m_req_o     (m_req)
     ,.m_yumi_i    (m_yumi)
     ,.m_v_i       (rsp_m_v)
     ,.m_data_i    (rsp_m_data)
    );

  bank_crossbar i_bank_crossbar
    ( .clk_i      (clk_i)
     ,.reset_i    (reset_i)
     ,.m_v_i      (m_v)
     ,.m_req_i    (m_req)
     ,.m_yumi_o   (m_yumi)
     ,.bank_v_o   (bank_v)
     ,.bank_req_o (bank_req)
    );

  for (genvar b = 0; b < num_banks_lp; b++)
  begin : g_bank
    mem_bank i_mem_bank
      ( .clk_i   (clk_i)
       ,.reset_i (reset_i)
       ,.v_i     (bank_v[b])
       ,.req_i   (bank_req[b])
       ,.rsp_v_o (rsp_v[b])
       ,.rsp_o   (bank_rsp[b])
      );
  end

  bank_response_mux i_bank_response_mux
    ( .rsp_v_i  (rsp_v)
     ,.rsp_i    (bank_rsp)
     ,.m_v_o    (rsp_m_v)
     ,.m_data_o (rsp_m_data)
    );

endmodule

// ==== verilog/mem_sys_pkg.sv ====
package mem_sys_pkg;

  // --------------------------------------------------------------------------
  // sizes of the tile memory system
  // --------------------------------------------------------------------------
  localparam int num_ports_lp   = 2;    // port 0 is instruction, port 1 is data.
  localparam int num_banks_lp   = 4;
  localparam int bank_words_lp  = 256;
  localparam int haddr_width_lp = 32;
  localparam int hdata_width_lp = 32;

  typedef logic [haddr_width_lp-1:0]         haddr_t;
  typedef logic [hdata_width_lp-1:0]         hdata_t;
  typedef logic [(hdata_width_lp>>3)-1:0]    hmask_t;
  typedef logic [1:0]                        htrans_t;
  typedef logic [2:0]                        hsize_t;
  typedef logic [$clog2(num_banks_lp)-1:0]   bank_id_t;
  typedef logic [$clog2(bank_words_lp)-1:0]  bank_addr_t;
  typedef logic [$clog2(num_ports_lp)-1:0]   port_id_t;

  // only the transfer and size codes that the core ever issues.
  localparam htrans_t htrans_idle_lp   = 2'b00;
  localparam htrans_t htrans_nonseq_lp = 2'b10;
  localparam hsize_t  hsize_byte_lp    = 3'b000;
  localparam hsize_t  hsize_half_lp    = 3'b001;
  localparam hsize_t  hsize_word_lp    = 3'b010;

  // --------------------------------------------------------------------------
  // bundles passed between the blocks
  // --------------------------------------------------------------------------
  typedef struct packed {
    haddr_t  haddr;
    logic    hwrite;
    hsize_t  hsize;
    htrans_t htrans;
    hdata_t  hwdata;
  } hasti_req_s;

  typedef struct packed {
    hdata_t hrdata;
    logic   hready;
  } hasti_rsp_s;

  typedef struct packed {
    logic   w;
    haddr_t addr;    // byte address, always word aligned.
    hdata_t data;
    hmask_t mask;
  } mem_req_s;

  typedef struct packed {
    logic       w;
    bank_addr_t bank_addr;
    hdata_t     data;
    hmask_t     mask;
    port_id_t   port;
  } bank_req_s;

  typedef struct packed {
    hdata_t   data;
    port_id_t port;
  } bank_rsp_s;

  typedef enum logic [1:0] {idle, wait_yumi, wait_rsp} conv_state_e;

endpackage
